/* verilog/ecc_secded_defs.svh */
`ifndef ECC_SECDED_DEFS_SVH
`define ECC_SECDED_DEFS_SVH

// ----------------------------------------
// code geometry
// ----------------------------------------

// data word carried by one codeword.
`define ECC_DATA_WIDTH 91

// 7 hamming bits plus one overall parity bit.
`define ECC_PARITY_WIDTH 8

// ----------------------------------------
// check bit layout
// ----------------------------------------

// low check bits hold the hamming position of a data bit.
`define ECC_HAMMING_BITS 7

// top check bit makes every column odd weight.
`define ECC_OVERALL_BIT 7

`endif

/* verilog/ecc_secded_pkg.sv */
`default_nettype none

`include "ecc_secded_defs.svh"

package ecc_secded_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;    // one data word.
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;  // check bits or syndrome.

    // result class of a read, same coding as the old error pair.
    typedef enum logic [1:0] {
        ECC_OK   = 2'b00,
        ECC_SBIT = 2'b01,
        ECC_DBIT = 2'b10
    } ecc_status_e;

    // ----------------------------------------
    // column code of data bit idx
    // ----------------------------------------
    // positions 1, 2, 4, ... belong to the check bits, so data bit idx
    // sits at the (idx+1)-th position of 3 or more that is not a power
    // of two.
    function automatic ecc_parity_t ecc_column(input int idx);
        int                          n;
        logic [`ECC_HAMMING_BITS-1:0] pos;
        ecc_parity_t                 col;
        n   = 0;
        pos = '0;
        for (int p = 3; p < (1 << `ECC_HAMMING_BITS); p++) begin
            if ((p & (p - 1)) != 0) begin  // skip powers of two.
                if (n == idx) begin
                    pos = p[`ECC_HAMMING_BITS-1:0];
                end
                n++;
            end
        end
        col = '0;
        col[`ECC_HAMMING_BITS-1:0] = pos;
        col[`ECC_OVERALL_BIT]      = ~(^pos);  // force odd column weight.
        return col;
    endfunction

    // ----------------------------------------
    // check bits of a data word
    // ----------------------------------------
    function automatic ecc_parity_t ecc_parity(input ecc_data_t d);
        ecc_parity_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            p = p ^ (ecc_column(i) & {`ECC_PARITY_WIDTH{d[i]}});  // bit i feeds its column.
        end
        return p;
    endfunction

endpackage

`default_nettype wire

/* verilog/ecc_write_path.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_write_path
    import ecc_secded_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  logic        wr_valid,
    input  ecc_data_t   wr_data,
    output logic        wr_out_valid,
    output ecc_parity_t wr_parity
);

    ecc_parity_t parity_next;

    // ----------------------------------------
    // encoder
    // ----------------------------------------

    always_comb begin
        parity_next = ecc_parity(wr_data);
    end

    // ----------------------------------------
    // output registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_out_valid <= 1'b0;
        end else begin
            wr_out_valid <= wr_valid;  // one cycle pulse per write.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            wr_parity <= parity_next;  // held until the next write.
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_syndrome_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_syndrome_stage
    import ecc_secded_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  logic        rd_valid,
    input  ecc_data_t   rd_data,
    input  ecc_parity_t rd_parity,
    input  logic        bypass,
    output logic        chk_valid,
    output ecc_data_t   chk_data,
    output ecc_parity_t chk_syndrome,
    output logic        chk_bypass
);

    ecc_parity_t syndrome;

    // ----------------------------------------
    // syndrome
    // ----------------------------------------

    // zero when stored and recomputed check bits agree.
    always_comb begin
        syndrome = ecc_parity(rd_data) ^ rd_parity;
    end

    // ----------------------------------------
    // stage registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chk_valid  <= 1'b0;
            chk_bypass <= 1'b0;
        end else begin
            chk_valid <= rd_valid;
            if (rd_valid) begin
                chk_bypass <= bypass;  // only acted on in stage 2.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            chk_data     <= rd_data;
            chk_syndrome <= syndrome;
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_correct_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_secded_defs.svh"

module ecc_correct_stage
    import ecc_secded_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  logic        chk_valid,
    input  ecc_data_t   chk_data,
    input  ecc_parity_t chk_syndrome,
    input  logic        chk_bypass,
    output logic        rd_out_valid,
    output ecc_data_t   data_out,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_status_e status;
    ecc_data_t   flip_mask;
    ecc_data_t   corrected;
    logic        sbit_next;
    logic        dbit_next;

    // ----------------------------------------
    // syndrome decode
    // ----------------------------------------

    always_comb begin
        flip_mask = '0;
        status    = ECC_DBIT;  // even weight, not a single error.
        if (chk_syndrome == '0) begin
            status = ECC_OK;
        end else if ($onehot(chk_syndrome)) begin
            status = ECC_SBIT;  // a check bit flipped, data is fine.
        end else begin
            for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
                if (chk_syndrome == ecc_column(i)) begin
                    flip_mask[i] = 1'b1;
                    status       = ECC_SBIT;
                end
            end
        end
    end

    // ----------------------------------------
    // correction and flags
    // ----------------------------------------

    always_comb begin
        if (chk_bypass) begin
            corrected = chk_data;
            sbit_next = 1'b0;
            dbit_next = 1'b0;
        end else begin
            corrected = chk_data ^ flip_mask;
            sbit_next = (status == ECC_SBIT);
            dbit_next = (status == ECC_DBIT);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_out_valid <= 1'b0;
            sbit_err     <= 1'b0;
            dbit_err     <= 1'b0;
        end else begin
            rd_out_valid <= chk_valid;
            sbit_err     <= chk_valid & sbit_next;  // low between reads.
            dbit_err     <= chk_valid & dbit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (chk_valid) begin
            data_out <= corrected;
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_secded_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_secded_top
    import ecc_secded_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  logic        wr_valid,
    input  ecc_data_t   wr_data,
    input  logic        rd_valid,
    input  ecc_data_t   rd_data,
    input  ecc_parity_t rd_parity,
    input  logic        bypass,
    output logic        wr_out_valid,
    output ecc_parity_t wr_parity,
    output logic        rd_out_valid,
    output ecc_data_t   data_out,
    output logic        sbit_err,
    output logic        dbit_err
);

    // read stage 1 to stage 2.
    logic        chk_valid;
    ecc_data_t   chk_data;
    ecc_parity_t chk_syndrome;
    logic        chk_bypass;

    // ----------------------------------------
    // write path
    // ----------------------------------------

    ecc_write_path u_write_path (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_out_valid (wr_out_valid),
        .wr_parity    (wr_parity)
    );

    // ----------------------------------------
    // read path
    // ----------------------------------------

    ecc_syndrome_stage u_syndrome_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_parity    (rd_parity),
        .bypass       (bypass),
        .chk_valid    (chk_valid),
        .chk_data     (chk_data),
        .chk_syndrome (chk_syndrome),
        .chk_bypass   (chk_bypass)
    );

    ecc_correct_stage u_correct_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .chk_valid    (chk_valid),
        .chk_data     (chk_data),
        .chk_syndrome (chk_syndrome),
        .chk_bypass   (chk_bypass),
        .rd_out_valid (rd_out_valid),
        .data_out     (data_out),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err)
    );

endmodule

`default_nettype wire

/* verification/ecc_secded_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_secded_checker
    import ecc_secded_pkg::*;
#(
    parameter int CLK_PERIOD = 20
) (
    input  wire         clk,
    input  wire         rst_n,
    input  logic        wr_out_valid,
    input  ecc_parity_t wr_parity,
    input  logic        rd_out_valid,
    input  ecc_data_t   data_out,
    input  logic        sbit_err,
    input  logic        dbit_err,
    output int          mismatch_count,
    output int          other_count,
    output int          pending
);

    // expected results with the time their strobe was driven.
    ecc_parity_t wr_exp_parity[$];
    time         wr_exp_time[$];
    ecc_data_t   rd_exp_data[$];
    ecc_status_e rd_exp_status[$];
    time         rd_exp_time[$];

    initial begin
        mismatch_count = 0;
        other_count    = 0;
        pending        = 0;
    end

    task automatic push_write(input ecc_parity_t parity);
        wr_exp_parity.push_back(parity);
        wr_exp_time.push_back($time);
        pending++;
    endtask

    task automatic push_read(input ecc_data_t data, input ecc_status_e status);
        rd_exp_data.push_back(data);
        rd_exp_status.push_back(status);
        rd_exp_time.push_back($time);
        pending++;
    endtask

    // ----------------------------------------
    // write path
    // ----------------------------------------

    task automatic check_write;
        ecc_parity_t exp_parity;
        time         t_strobe;
        if (wr_exp_parity.size() == 0) begin
            $display("error at %0t: wr_out_valid high with no write outstanding", $time);
            other_count++;
            return;
        end
        exp_parity = wr_exp_parity.pop_front();
        t_strobe   = wr_exp_time.pop_front();
        pending--;
        if ($time - t_strobe != CLK_PERIOD) begin
            $display("MISMATCH %0t: write result after %0t ns, expected 1 cycle",
                     $time, $time - t_strobe);
            mismatch_count++;
        end
        if (wr_parity !== exp_parity) begin
            $display("MISMATCH %0t: wr_parity %h, expected %h", $time, wr_parity, exp_parity);
            mismatch_count++;
        end
    endtask

    // ----------------------------------------
    // read path
    // ----------------------------------------

    task automatic check_read;
        ecc_data_t   exp_data;
        ecc_status_e exp_status;
        time         t_strobe;
        if (rd_exp_data.size() == 0) begin
            $display("error at %0t: rd_out_valid high with no read outstanding", $time);
            other_count++;
            return;
        end
        exp_data   = rd_exp_data.pop_front();
        exp_status = rd_exp_status.pop_front();
        t_strobe   = rd_exp_time.pop_front();
        pending--;
        if ($time - t_strobe != 2 * CLK_PERIOD) begin
            $display("MISMATCH %0t: read result after %0t ns, expected 2 cycles",
                     $time, $time - t_strobe);
            mismatch_count++;
        end
        if (data_out !== exp_data) begin
            $display("MISMATCH %0t: data_out %h, expected %h", $time, data_out, exp_data);
            mismatch_count++;
        end
        if (sbit_err !== (exp_status == ECC_SBIT) || dbit_err !== (exp_status == ECC_DBIT)) begin
            $display("MISMATCH %0t: flags sbit=%b dbit=%b, expected status %s",
                     $time, sbit_err, dbit_err, exp_status.name());
            mismatch_count++;
        end
    endtask

    // outputs only move on the rising edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (wr_out_valid) check_write();
            if (rd_out_valid) begin
                check_read();
            end else if (sbit_err || dbit_err) begin
                $display("error at %0t: error flag high without rd_out_valid", $time);
                other_count++;
            end
        end
    end

    task automatic final_check;
        if (wr_exp_parity.size() != 0) begin
            $display("error: %0d writes never produced a result", wr_exp_parity.size());
            other_count += wr_exp_parity.size();
        end
        if (rd_exp_data.size() != 0) begin
            $display("error: %0d reads never produced a result", rd_exp_data.size());
            other_count += rd_exp_data.size();
        end
    endtask

endmodule

`default_nettype wire

/* verification/ecc_secded_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_secded_tb
    import ecc_secded_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_LIMIT = 8;

    logic        clk;
    logic        rst_n;
    logic        wr_valid;
    ecc_data_t   wr_data;
    logic        rd_valid;
    ecc_data_t   rd_data;
    ecc_parity_t rd_parity;
    logic        bypass;
    logic        wr_out_valid;
    ecc_parity_t wr_parity;
    logic        rd_out_valid;
    ecc_data_t   data_out;
    logic        sbit_err;
    logic        dbit_err;

    int mismatch_count;
    int other_count;
    int pending;
    int file_errors;
    int cycle_count;
    int timeout_limit;
    int rand_init;
    int total_errors;
    int drain_cycles;

    // vectors as read from the test file.
    logic        vec_is_read[$];
    logic        vec_bypass[$];
    ecc_data_t   vec_data[$];
    ecc_parity_t vec_parity[$];
    ecc_data_t   vec_exp_data[$];
    ecc_parity_t vec_exp_parity[$];
    ecc_status_e vec_status[$];

    ecc_secded_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_parity    (rd_parity),
        .bypass       (bypass),
        .wr_out_valid (wr_out_valid),
        .wr_parity    (wr_parity),
        .rd_out_valid (rd_out_valid),
        .data_out     (data_out),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err)
    );

    ecc_secded_checker #(.CLK_PERIOD(CLK_PERIOD)) chk0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_out_valid   (wr_out_valid),
        .wr_parity      (wr_parity),
        .rd_out_valid   (rd_out_valid),
        .data_out       (data_out),
        .sbit_err       (sbit_err),
        .dbit_err       (dbit_err),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // test file reader
    // ----------------------------------------

    task automatic load_vectors;
        int               fd;
        int               code;
        int               byp;
        logic [31:0]      tok;
        logic [31:0]      stat_tok;
        logic [8*128-1:0] rest;
        ecc_data_t        dat;
        ecc_data_t        edat;
        ecc_parity_t      par;
        ecc_parity_t      epar;
        logic             done;
        fd = $fopen("verification/ecc_secded_tests.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open verification/ecc_secded_tests.txt");
            file_errors++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);  // rest of a comment line.
            end else begin
                code = $fscanf(fd, "%d %h %h %h %h %s", byp, dat, par, edat, epar, stat_tok);
                if (code != 6 || (tok != "W" && tok != "R") ||
                    (stat_tok != "OK" && stat_tok != "SBIT" && stat_tok != "DBIT")) begin
                    $display("error: malformed line after vector %0d in test file",
                             vec_data.size());
                    file_errors++;
                    done = 1'b1;
                end else begin
                    vec_is_read.push_back(tok == "R");
                    vec_bypass.push_back(byp != 0);
                    vec_data.push_back(dat);
                    vec_parity.push_back(par);
                    vec_exp_data.push_back(edat);
                    vec_exp_parity.push_back(epar);
                    if (stat_tok == "SBIT") vec_status.push_back(ECC_SBIT);
                    else if (stat_tok == "DBIT") vec_status.push_back(ECC_DBIT);
                    else vec_status.push_back(ECC_OK);
                end
            end
        end
        $fclose(fd);
        if (vec_data.size() == 0) begin
            $display("error: test file holds no vectors");
            file_errors++;
        end
    endtask

    // ----------------------------------------
    // driver
    // ----------------------------------------

    // every even read that follows a read goes back to back.
    function automatic int idle_gap(input int idx);
        if (idx > 0 && (idx % 2) == 0 && vec_is_read[idx] && vec_is_read[idx-1]) begin
            return 0;
        end
        return $urandom % 3;
    endfunction

    task automatic apply_vector(input int idx);
        if (vec_is_read[idx]) begin
            rd_valid  = 1'b1;
            rd_data   = vec_data[idx];
            rd_parity = vec_parity[idx];
            bypass    = vec_bypass[idx];
            chk0.push_read(vec_exp_data[idx], vec_status[idx]);
        end else begin
            wr_valid = 1'b1;
            wr_data  = vec_data[idx];
            chk0.push_write(vec_exp_parity[idx]);
        end
        @(negedge clk);
        wr_valid = 1'b0;
        rd_valid = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        wr_valid      = 1'b0;
        wr_data       = '0;
        rd_valid      = 1'b0;
        rd_data       = '0;
        rd_parity     = '0;
        bypass        = 1'b0;
        file_errors   = 0;
        timeout_limit = 0;
        drain_cycles  = 0;
        rand_init     = $urandom(32'h9b44214f);
        load_vectors();
        timeout_limit = 3 * vec_data.size() + 40;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < vec_data.size(); i++) begin
            repeat (idle_gap(i)) @(negedge clk);
            apply_vector(i);
        end
        while (pending != 0 && drain_cycles < DRAIN_LIMIT) begin  // drain both paths.
            @(posedge clk);
            drain_cycles++;
        end
        repeat (2) @(negedge clk);
        chk0.final_check();
        total_errors = mismatch_count + other_count + file_errors;
        $display("errors: %0d mismatches, %0d protocol, %0d test file",
                 mismatch_count, other_count, file_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ----------------------------------------
    // timeout
    // ----------------------------------------

    initial cycle_count = 0;

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("error: run did not finish within %0d cycles", timeout_limit);
            $display("Something failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/ecc_secded_tests.txt */
# kind bypass data parity exp_data exp_parity status
# kind W or R, data and parity fields in hex, status OK, SBIT or DBIT
W 0 00000000000000000000000 00 00000000000000000000000 00 OK
W 0 00000000000000000000001 00 00000000000000000000001 83 OK
R 0 00000000000000000000001 83 00000000000000000000001 83 OK
W 0 40000000000000000000000 00 40000000000000000000000 62 OK
R 0 40000000000000000000000 62 40000000000000000000000 62 OK
W 0 0000000000000000000000f 00 0000000000000000000000f 87 OK
W 0 000000000000000000000f0 00 000000000000000000000f0 84 OK
W 0 000000000000000000000ff 00 000000000000000000000ff 03 OK
R 0 0000000000000000000000f 87 0000000000000000000000f 87 OK
R 0 000000000000000000000f0 84 000000000000000000000f0 84 OK
R 0 000000000000000000000ff 03 000000000000000000000ff 03 OK
W 0 00000000200000004000000 00 00000000200000004000000 60 OK
W 0 60000000000000000000000 00 60000000000000000000000 03 OK
W 0 00000018000000000000000 00 00000018000000000000000 0f OK
R 0 00000000200000004000000 60 00000000200000004000000 60 OK
R 0 60000000000000000000000 03 60000000000000000000000 03 OK
R 0 00000018000000000000000 0f 00000018000000000000000 0f OK
W 0 00000000000000180001800 00 00000000000000180001800 82 OK
W 0 00100000101010000000000 00 00100000101010000000000 ff OK
W 0 00000000000000000000f00 00 00000000000000000000f00 1d OK
R 0 00000000000000180001800 82 00000000000000180001800 82 OK
R 0 00100000101010000000000 ff 00100000101010000000000 ff OK
R 0 00000000000000000000f00 1d 00000000000000000000f00 1d OK
R 0 00000000000000000000000 00 00000000000000000000000 00 OK
R 0 0000000000000000000000e 87 0000000000000000000000f 87 SBIT
R 0 40100000101010000000000 ff 00100000101010000000000 ff SBIT
R 0 00000000200000000000000 60 00000000200000004000000 60 SBIT
R 0 00000000200000000000000 00 00000000000000000000000 00 SBIT
R 0 00000000000000180000800 82 00000000000000180001800 82 SBIT
R 0 000000000000000000000d0 84 000000000000000000000f0 84 SBIT
R 0 00000010000000000000000 0f 00000018000000000000000 0f SBIT
R 0 00000000000000000000001 82 00000000000000000000001 82 SBIT
R 0 000000000000000000000ff 83 000000000000000000000ff 83 SBIT
R 0 00000018000000000000000 1f 00000018000000000000000 1f SBIT
R 0 0000000000000000000000c 87 0000000000000000000000c 87 DBIT
R 0 00100000101000000000000 fe 00100000101000000000000 fe DBIT
R 0 00000000000000000000000 03 00000000000000000000000 03 DBIT
R 0 00000000000000000000c00 1d 00000000000000000000c00 1d DBIT
R 1 0000000000000000000000e 87 0000000000000000000000e 87 OK
R 1 00100000101000000000000 fe 00100000101000000000000 fe OK

/* ecc_secded.f */
+incdir+verilog
verilog/ecc_secded_pkg.sv
verilog/ecc_write_path.sv
verilog/ecc_syndrome_stage.sv
verilog/ecc_correct_stage.sv
verilog/ecc_secded_top.sv
verification/ecc_secded_checker.sv
verification/ecc_secded_tb.sv

/* Bender.yml */
package:
  name: ecc_secded

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ecc_secded_pkg.sv
      - verilog/ecc_write_path.sv
      - verilog/ecc_syndrome_stage.sv
      - verilog/ecc_correct_stage.sv
      - verilog/ecc_secded_top.sv
  - target: test
    files:
      - verification/ecc_secded_checker.sv
      - verification/ecc_secded_tb.sv
